// ==== compile.f ====
+incdir+.
ahbPkg.sv
apbPkg.sv
ahbPipeIf.sv
ahbSlaveInterface.sv
apbController.sv
ahbApbBridge.sv
tbClock.sv
tbAhbApbBridge.sv

// ==== Makefile ====
# Verilator build and run of the AHB to APB bridge testbench.
VERILATOR ?= verilator
TOP ?= tbAhbApbBridge
FILELIST ?= compile.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
PASS_MSG ?= NO ERRORS
VFLAGS ?= --binary --timing -j 0

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(wildcard *.sv) $(wildcard *.svh)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tbAhbApbBridge.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the AHB-Lite to APB bridge.
// Directed tests, an APB monitor, a Prdata model and a watchdog.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "bridge_consts.svh"

module tbAhbApbBridge
	import ahbPkg::*, apbPkg::*;
	();

	typedef struct packed
	{
		haddrT addr;
		hdataT data;
		logic write;
	} xferT;

	// 48 address phases are issued over all tests.
	localparam int issuedXfers = 48;
	localparam int timeoutLimit = 4 * issuedXfers + 50;

	logic Hclk;
	logic Hresetn;
	logic Hwrite;
	logic Hreadyin;
	htransT Htrans;
	haddrT Haddr;
	hdataT Hwdata;
	logic Hreadyout;
	hdataT Hrdata;
	haddrT Paddr;
	hdataT Pwdata;
	logic Pwrite;
	pselT Pselx;
	logic Penable;
	hdataT Prdata;

	xferT expQ[$];
	hdataT pendData;
	int cycleCnt = 0;
	int acceptCycle = 0;
	int lastEnableCycle = 0;
	int enableCount = 0;
	int valueErrors = 0;
	int otherErrors = 0;
	logic inSetup = 1'b0;
	logic quietBus = 1'b0;

	tbClock clockGen
	(
		.Hclk(Hclk),
		.Hresetn(Hresetn)
	);

	ahbApbBridge DUT
	(
		.Hclk(Hclk),
		.Hresetn(Hresetn),
		.Hwrite(Hwrite),
		.Hreadyin(Hreadyin),
		.Htrans(Htrans),
		.Haddr(Haddr),
		.Hwdata(Hwdata),
		.Hreadyout(Hreadyout),
		.Hrdata(Hrdata),
		.Paddr(Paddr),
		.Pwdata(Pwdata),
		.Pwrite(Pwrite),
		.Pselx(Pselx),
		.Penable(Penable),
		.Prdata(Prdata)
	);

	// single slave on the AHB side, so its ready loops back.
	assign Hreadyin = Hreadyout;

	// peripheral read data, a fixed mix of the whole address.
	function automatic hdataT prdataFor(input haddrT addr);
		return {addr[15:0], ~addr[31:16]} ^ 32'h3c3c_5a5a;
	endfunction

	// windows are contiguous, one per peripheral.
	function automatic pselT selectFor(input haddrT addr);
		int unsigned idx;
		if (addr < `SLAVE0_BASE)
			return '0;
		idx = (addr - `SLAVE0_BASE) / `SLAVE_SPAN;
		if (idx >= `NUM_SLAVES)
			return '0;
		return pselT'(1) << idx;
	endfunction

	assign Prdata = prdataFor(Paddr);

	task automatic checkApbXfer(input haddrT expAddr, input haddrT gotAddr,
		input hdataT expData, input hdataT gotData, input logic expWrite, input logic gotWrite,
		input pselT expSel, input pselT gotSel);
		if (gotAddr !== expAddr)
		begin
			valueErrors++;
			$display("FAIL at %0t: Paddr expected %h got %h", $time, expAddr, gotAddr);
		end
		if (gotWrite !== expWrite)
		begin
			valueErrors++;
			$display("FAIL at %0t: Pwrite expected %b got %b", $time, expWrite, gotWrite);
		end
		if (gotSel !== expSel)
		begin
			valueErrors++;
			$display("FAIL at %0t: Pselx expected %b got %b", $time, expSel, gotSel);
		end
		if (expWrite && (gotData !== expData))
		begin
			valueErrors++;
			$display("FAIL at %0t: Pwdata expected %h got %h", $time, expData, gotData);
		end
	endtask

	task automatic checkReadData(input hdataT expData, input hdataT gotData);
		if (gotData !== expData)
		begin
			valueErrors++;
			$display("FAIL at %0t: Hrdata expected %h got %h", $time, expData, gotData);
		end
	endtask

	task automatic checkFlag(input logic expVal, input logic gotVal, input string what);
		if (gotVal !== expVal)
		begin
			valueErrors++;
			$display("FAIL at %0t: %s expected %b got %b", $time, what, expVal, gotVal);
		end
	endtask

	task automatic checkSelect(input pselT expSel, input pselT gotSel, input string what);
		if (gotSel !== expSel)
		begin
			valueErrors++;
			$display("FAIL at %0t: %s expected %b got %b", $time, what, expSel, gotSel);
		end
	endtask

	task automatic checkLatency(input int expCycle, input int gotCycle, input string what);
		if (gotCycle != expCycle)
		begin
			valueErrors++;
			$display("FAIL at %0t: %s in cycle %0d, expected %0d", $time, what, gotCycle,
				expCycle);
		end
	endtask

	task automatic printSummary();
		$display("summary: %0d value errors, %0d other errors, %0d APB transfers seen",
			valueErrors, otherErrors, enableCount);
	endtask

	// holds the address phase until accepted; the prior write data rides along.
	task automatic driveAddressPhase(input htransT kind, input logic write, input haddrT addr,
		input hdataT data);
		xferT item;
		Htrans = kind;
		Hwrite = write;
		Haddr = addr;
		Hwdata = pendData;
		@(negedge Hclk);
		while (!Hreadyout)
			@(negedge Hclk);
		@(posedge Hclk);
		#10;
		acceptCycle = cycleCnt;
		pendData = data;
		if (((kind == NONSEQ) || (kind == SEQ)) && (selectFor(addr) != '0))
		begin
			item.addr = addr;
			item.data = data;
			item.write = write;
			expQ.push_back(item);
		end
	endtask

	task automatic drainBus();
		driveAddressPhase(IDLE, 1'b0, '0, '0);
		while (expQ.size() != 0)
		begin
			@(posedge Hclk);
			#10;
		end
	endtask

	task automatic idleAfterReset();
		repeat (6)
		begin
			driveAddressPhase(IDLE, 1'b0, `SLAVE1_BASE, '0);
			checkSelect('0, Pselx, "Pselx while idle");
			checkFlag(1'b0, Penable, "Penable while idle");
			checkFlag(1'b1, Hreadyout, "Hreadyout while idle");
		end
	endtask

	task automatic singleReads();
		haddrT addr;
		int start;
		for (int i = 0; i < `NUM_SLAVES; i++)
		begin
			addr = `SLAVE0_BASE + i * `SLAVE_SPAN + 32'h40 + i * 4;
			driveAddressPhase(NONSEQ, 1'b0, addr, '0);
			start = acceptCycle;
			drainBus();
			// setup right after the address phase, then enable.
			checkLatency(start + 1, lastEnableCycle, "read enable");
		end
	endtask

	task automatic singleWrite();
		driveAddressPhase(NONSEQ, 1'b1, `SLAVE2_BASE + 32'h100, 32'hcafe_0123);
		drainBus();
	endtask

	task automatic backToBackWrites();
		haddrT addr;
		htransT kind;
		for (int i = 0; i < 4; i++)
		begin
			addr = `SLAVE0_BASE + (i % 3) * `SLAVE_SPAN + 32'h200 + i * 4;
			kind = (i == 0) ? NONSEQ : SEQ;
			driveAddressPhase(kind, 1'b1, addr, 32'hd00d_0000 + i);
		end
		drainBus();
	endtask

	task automatic ignoredTransfers();
		quietBus = 1'b1;
		driveAddressPhase(IDLE, 1'b1, `SLAVE0_BASE + 32'h8, 32'h1);
		driveAddressPhase(BUSY, 1'b0, `SLAVE1_BASE + 32'h8, 32'h2);
		driveAddressPhase(BUSY, 1'b1, `SLAVE2_BASE + 32'h8, 32'h3);
		driveAddressPhase(NONSEQ, 1'b0, 32'h1000_0000, 32'h4);
		driveAddressPhase(NONSEQ, 1'b1, `SLAVE2_BASE + `SLAVE_SPAN, 32'h5);
		driveAddressPhase(SEQ, 1'b0, `SLAVE0_BASE - 4, 32'h6);
		driveAddressPhase(IDLE, 1'b0, '0, '0);
		driveAddressPhase(IDLE, 1'b0, '0, '0);
		quietBus = 1'b0;
	endtask

	task automatic randomMix(input int count);
		haddrT addr;
		hdataT data;
		logic [31:0] pick;
		for (int i = 0; i < count; i++)
		begin
			addr = `SLAVE0_BASE + ($urandom % `NUM_SLAVES) * `SLAVE_SPAN;
			addr = addr + ($urandom & (`SLAVE_SPAN - 1) & 32'hffff_fffc);
			data = $urandom;
			pick = $urandom;
			driveAddressPhase(((i == 0) || pick[1]) ? NONSEQ : SEQ, pick[0], addr, data);
		end
		drainBus();
	endtask

	// every enable cycle must match the oldest issued transfer.
	always @(negedge Hclk)
	begin : apbMonitor
		xferT exp;
		if (Hresetn)
		begin
			if (quietBus)
				checkSelect('0, Pselx, "Pselx on an ignored transfer");
			if (inSetup && !Penable)
			begin
				otherErrors++;
				$display("error at %0t: setup cycle was not followed by an enable cycle", $time);
			end
			if (Penable)
			begin
				if (!inSetup)
				begin
					otherErrors++;
					$display("error at %0t: enable cycle came without a setup cycle", $time);
				end
				if (expQ.size() == 0)
				begin
					otherErrors++;
					$display("error at %0t: APB transfer to %h was never issued", $time, Paddr);
				end
				else
				begin
					exp = expQ.pop_front();
					checkApbXfer(exp.addr, Paddr, exp.data, Pwdata, exp.write, Pwrite,
						selectFor(exp.addr), Pselx);
					// a read data phase ends in its enable cycle.
					if (!exp.write)
					begin
						checkFlag(1'b1, Hreadyout, "Hreadyout in read enable cycle");
						checkReadData(prdataFor(exp.addr), Hrdata);
					end
				end
				enableCount++;
				lastEnableCycle = cycleCnt;
			end
			else if (|Pselx)
				checkFlag(1'b0, Hreadyout, "Hreadyout in setup cycle");
			inSetup = (|Pselx) && !Penable;
		end
	end

	always @(posedge Hclk)
	begin : watchdog
		apbStateT stuckState;
		cycleCnt++;
		if (cycleCnt > timeoutLimit)
		begin
			stuckState = DUT.uCtrl.state;
			otherErrors++;
			$display("timeout: the tests did not finish within %0d cycles, controller in %s",
				timeoutLimit, stuckState.name());
			printSummary();
			$display("ERRORS FOUND");
			$finish;
		end
	end

	initial
	begin
		void'($urandom(32'ha4b12ec6));
		Htrans = IDLE;
		Hwrite = 1'b0;
		Haddr = '0;
		Hwdata = '0;
		pendData = '0;
		wait (Hresetn === 1'b1);
		@(posedge Hclk);
		#10;
		idleAfterReset();
		singleReads();
		singleWrite();
		backToBackWrites();
		ignoredTransfers();
		randomMix(20);
		printSummary();
		if ((valueErrors + otherErrors) == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

// ==== tbClock.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench clock and reset generator.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module tbClock
(
	output logic Hclk,
	output logic Hresetn
);

	localparam int halfPeriod = 50;

	initial
	begin
		Hclk = 1'b0;
		forever
			#halfPeriod Hclk = ~Hclk;
	end

	// reset held for four rising edges.
	initial
	begin
		Hresetn = 1'b0;
		repeat (4)
			@(posedge Hclk);
		#10;
		Hresetn = 1'b1;
	end

endmodule

// ==== ahbApbBridge.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// AHB-Lite to APB bridge top level.
// Joins the AHB front end and the APB controller.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module ahbApbBridge
	import ahbPkg::*, apbPkg::*;
(
	input logic Hclk,
	input logic Hresetn,
	input logic Hwrite,
	input logic Hreadyin,
	input htransT Htrans,
	input haddrT Haddr,
	input hdataT Hwdata,
	output logic Hreadyout,
	output hdataT Hrdata,
	output haddrT Paddr,
	output hdataT Pwdata,
	output logic Pwrite,
	output pselT Pselx,
	output logic Penable,
	input hdataT Prdata
);

	ahbPipeIf pipe ();

	ahbSlaveInterface uFront
	(
		.Hclk(Hclk),
		.Hresetn(Hresetn),
		.Hwrite(Hwrite),
		.Hreadyin(Hreadyin),
		.Htrans(Htrans),
		.Haddr(Haddr),
		.Hwdata(Hwdata),
		.pipe(pipe.front)
	);

	apbController uCtrl
	(
		.Hclk(Hclk),
		.Hresetn(Hresetn),
		.pipe(pipe.ctrl),
		.Paddr(Paddr),
		.Pwdata(Pwdata),
		.Pwrite(Pwrite),
		.Pselx(Pselx),
		.Penable(Penable),
		.Hreadyout(Hreadyout)
	);

	// read data is valid in the enable cycle.
	assign Hrdata = Prdata;

endmodule

// ==== apbController.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// APB transfer controller.
// Eight-state FSM with registered APB outputs and AHB stall control.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module apbController
	import ahbPkg::*, apbPkg::*;
(
	input logic Hclk,
	input logic Hresetn,
	ahbPipeIf.ctrl pipe,
	output haddrT Paddr,
	output hdataT Pwdata,
	output logic Pwrite,
	output pselT Pselx,
	output logic Penable,
	output logic Hreadyout
);

	apbStateT state;
	apbStateT nextState;

	haddrT paddrNext;
	hdataT pwdataNext;
	logic pwriteNext;
	pselT pselNext;
	logic penableNext;
	logic hreadyNext;

	always_ff @(posedge Hclk)
	begin
		if (!Hresetn)
			state <= stIdle;
		else
			state <= nextState;
	end

	always_comb
	begin
		nextState = state;
		case (state)
			stIdle, stRenable, stWenable:
			begin
				if (!pipe.valid)
					nextState = stIdle;
				else if (pipe.hwrite)
					nextState = stWwait;
				else
					nextState = stRead;
			end
			stWwait:
			begin
				// a second transfer accepted during the data phase.
				if (pipe.valid)
					nextState = stWriteP;
				else
					nextState = stWrite;
			end
			stRead:
				nextState = stRenable;
			stWrite:
				nextState = stWenable;
			stWriteP:
				nextState = stWenableP;
			stWenableP:
			begin
				if (!pipe.hwriteReg)
					nextState = stRead;
				else if (pipe.valid)
					nextState = stWriteP;
				else
					nextState = stWrite;
			end
			default:
				nextState = stIdle;
		endcase
	end

	// next values of the registered APB outputs.
	always_comb
	begin
		paddrNext = Paddr;
		pwdataNext = Pwdata;
		pwriteNext = Pwrite;
		pselNext = Pselx;
		penableNext = 1'b0;
		hreadyNext = 1'b1;
		case (state)
			stIdle, stRenable, stWenable:
			begin
				pselNext = '0;
				if (pipe.valid && !pipe.hwrite)
				begin
					paddrNext = pipe.haddr;
					pwriteNext = 1'b0;
					pselNext = pipe.tempSelx;
					hreadyNext = 1'b0;
				end
			end
			stWwait:
			begin
				// write data is on the bus in this data phase.
				paddrNext = pipe.haddr1;
				pwdataNext = pipe.hwdata;
				pwriteNext = 1'b1;
				pselNext = addrToSel(pipe.haddr1);
				hreadyNext = 1'b0;
			end
			stRead, stWrite:
			begin
				penableNext = 1'b1;
			end
			stWriteP:
			begin
				// first write stays on the bus from the older stage.
				paddrNext = pipe.haddr2;
				pwdataNext = pipe.hwdata1;
				penableNext = 1'b1;
				// a pending read must not complete before its APB access.
				hreadyNext = pipe.hwriteReg;
			end
			stWenableP:
			begin
				// second transfer sits in the first stage.
				paddrNext = pipe.haddr1;
				pwriteNext = pipe.hwriteReg;
				pselNext = addrToSel(pipe.haddr1);
				hreadyNext = 1'b0;
				if (pipe.hwriteReg)
					pwdataNext = pipe.hwdata;
			end
			default:
			begin
				pselNext = '0;
			end
		endcase
	end

	always_ff @(posedge Hclk)
	begin
		if (!Hresetn)
		begin
			Pwrite <= 1'b0;
			Pselx <= '0;
			Penable <= 1'b0;
			Hreadyout <= 1'b1;
		end
		else
		begin
			Pwrite <= pwriteNext;
			Pselx <= pselNext;
			Penable <= penableNext;
			Hreadyout <= hreadyNext;
		end
	end

	always_ff @(posedge Hclk)
	begin
		Paddr <= paddrNext;
		Pwdata <= pwdataNext;
	end

endmodule

// ==== ahbSlaveInterface.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// AHB slave front end.
// Qualifies transfers, decodes the APB select, pipelines address/data.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module ahbSlaveInterface
	import ahbPkg::*, apbPkg::*;
(
	input logic Hclk,
	input logic Hresetn,
	input logic Hwrite,
	input logic Hreadyin,
	input htransT Htrans,
	input haddrT Haddr,
	input hdataT Hwdata,
	ahbPipeIf.front pipe
);

	pselT selNow;
	logic isXfer;
	haddrT addrStage1;
	haddrT addrStage2;
	hdataT dataStage1;
	hdataT dataStage2;
	logic writeStage;

	assign selNow = addrToSel(Haddr);

	// only NONSEQ and SEQ move data. IDLE and BUSY are ignored.
	assign isXfer = (Htrans == NONSEQ) || (Htrans == SEQ);

	assign pipe.valid = isXfer && Hreadyin && (|selNow);
	assign pipe.tempSelx = selNow;

	// stages freeze while the bridge stalls the master.
	always_ff @(posedge Hclk)
	begin
		if (Hreadyin)
		begin
			addrStage1 <= Haddr;
			addrStage2 <= addrStage1;
			dataStage1 <= Hwdata;
			dataStage2 <= dataStage1;
		end
	end

	always_ff @(posedge Hclk)
	begin
		if (!Hresetn)
		begin
			writeStage <= 1'b0;
		end
		else if (Hreadyin)
		begin
			writeStage <= Hwrite;
		end
	end

	assign pipe.haddr1 = addrStage1;
	assign pipe.haddr2 = addrStage2;
	assign pipe.hwdata1 = dataStage1;
	assign pipe.hwdata2 = dataStage2;
	assign pipe.hwriteReg = writeStage;

	assign pipe.haddr = Haddr;
	assign pipe.hwdata = Hwdata;
	assign pipe.hwrite = Hwrite;

endmodule

// ==== ahbPipeIf.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Qualified AHB transfer pipeline.
// Carries the decoded transfer from the AHB front end to the APB FSM.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
interface ahbPipeIf
	import ahbPkg::*, apbPkg::*;
	();

	logic valid;
	haddrT haddr1;
	haddrT haddr2;
	hdataT hwdata1;
	hdataT hwdata2;
	logic hwriteReg;
	pselT tempSelx;

	// current AHB values.
	haddrT haddr;
	hdataT hwdata;
	logic hwrite;

	modport front
	(
		output valid, haddr1, haddr2, hwdata1, hwdata2, hwriteReg, tempSelx,
		output haddr, hwdata, hwrite
	);

	modport ctrl
	(
		input valid, haddr1, haddr2, hwdata1, hwdata2, hwriteReg, tempSelx,
		input haddr, hwdata, hwrite
	);

endinterface

// ==== apbPkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// APB-side types.
// Controller states, the one-hot select and the address map decode.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "bridge_consts.svh"

package apbPkg;

	typedef enum logic [2:0]
	{
		stIdle,
		stWwait,
		stRead,
		stWrite,
		stWriteP,
		stRenable,
		stWenable,
		stWenableP
	} apbStateT;

	typedef logic [`NUM_SLAVES-1:0] pselT;

	// all zero for an unmapped address.
	function automatic pselT addrToSel(input ahbPkg::haddrT addr);
		pselT sel;
		sel = '0;
		sel[0] = (addr >= `SLAVE0_BASE) && (addr < `SLAVE0_BASE + `SLAVE_SPAN);
		sel[1] = (addr >= `SLAVE1_BASE) && (addr < `SLAVE1_BASE + `SLAVE_SPAN);
		sel[2] = (addr >= `SLAVE2_BASE) && (addr < `SLAVE2_BASE + `SLAVE_SPAN);
		return sel;
	endfunction

endpackage

// ==== ahbPkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// AHB-side types.
// Address and data words and the transfer kinds.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "bridge_consts.svh"

package ahbPkg;

	typedef logic [`ADDR_WIDTH-1:0] haddrT;

	// shared by the AHB and APB data paths.
	typedef logic [`DATA_WIDTH-1:0] hdataT;

	typedef enum logic [1:0]
	{
		IDLE   = 2'b00,
		BUSY   = 2'b01,
		NONSEQ = 2'b10,
		SEQ    = 2'b11
	} htransT;

endpackage

// ==== bridge_consts.svh ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// AHB-Lite to APB bridge constants.
// Bus widths, peripheral count and the APB address map.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef BRIDGE_CONSTS_SVH
`define BRIDGE_CONSTS_SVH

`define ADDR_WIDTH 32
`define DATA_WIDTH 32

// three APB peripherals behind the bridge.
`define NUM_SLAVES 3

// each peripheral owns one 64 MB window.
`define SLAVE0_BASE 32'h8000_0000
`define SLAVE1_BASE 32'h8400_0000
`define SLAVE2_BASE 32'h8800_0000
`define SLAVE_SPAN  32'h0400_0000

`endif
